//--- ir_pkg.sv
package ir_pkg;

    // Decoded NEC frame, first received bit lands in bit 0
    typedef struct packed {
        logic [7:0] inv_command;  // Bits 31..24
        logic [7:0] command;      // Bits 23..16
        logic [7:0] inv_address;  // Bits 15..8
        logic [7:0] address;      // Bits 7..0
    } ir_word_t;

    typedef logic [2:0] state_t;  // State control value

    // NEC lengths in units of one 562.5 us bit mark
    localparam int unsigned LEADER_MARK_UNITS  = 16;
    localparam int unsigned LEADER_SPACE_UNITS = 8;
    localparam int unsigned REPEAT_SPACE_UNITS = 4;  // Leader space of a repeat code
    localparam int unsigned BIT_MARK_UNITS     = 1;  // Mark ahead of every bit and the stop mark
    localparam int unsigned ZERO_SPACE_UNITS   = 1;
    localparam int unsigned ONE_SPACE_UNITS    = 3;

    // Remote command codes, low three bits give the state
    localparam logic [7:0] CMD_STOP    = 8'h40;
    localparam logic [7:0] CMD_FORWARD = 8'h41;
    localparam logic [7:0] CMD_BACK    = 8'h42;
    localparam logic [7:0] CMD_LEFT    = 8'h43;
    localparam logic [7:0] CMD_RIGHT   = 8'h44;
    localparam logic [7:0] CMD_SLOW    = 8'h45;
    localparam logic [7:0] CMD_FAST    = 8'h46;
    localparam logic [7:0] CMD_HOLD    = 8'h47;
    localparam logic [7:0] CMD_TOGGLE  = 8'h1F;  // Flips the toggle level

    // ASCII digit sent on the UART for a state
    function automatic logic [7:0] state_to_ascii(state_t state);
        return 8'h30 + {5'b00000, state};
    endfunction

endpackage

//--- ir_nec_receiver.sv
`timescale 1ns/1ns

module ir_nec_receiver import ir_pkg::*; #(
    parameter int unsigned CLOCKS_PER_UNIT = 28125  // Clocks per 562.5 us unit
) (
    input  logic     clock_50,
    input  logic     reset,
    input  logic     ir_rxd,      // Low during an IR mark
    output logic     data_ready,  // One-cycle strobe per valid frame
    output ir_word_t ir_data      // Last valid frame, held
);

    // Tolerance is half a unit either way
    localparam int unsigned HALF_UNIT = CLOCKS_PER_UNIT / 2;
    localparam int unsigned CNT_W = $clog2((LEADER_MARK_UNITS + 1) * CLOCKS_PER_UNIT);

    typedef logic [CNT_W-1:0] count_t;

    localparam count_t LEAD_MARK_MIN  = count_t'(LEADER_MARK_UNITS * CLOCKS_PER_UNIT - HALF_UNIT);
    localparam count_t LEAD_MARK_MAX  = count_t'(LEADER_MARK_UNITS * CLOCKS_PER_UNIT + HALF_UNIT);
    localparam count_t LEAD_SPACE_MIN = count_t'(LEADER_SPACE_UNITS * CLOCKS_PER_UNIT - HALF_UNIT);
    localparam count_t LEAD_SPACE_MAX = count_t'(LEADER_SPACE_UNITS * CLOCKS_PER_UNIT + HALF_UNIT);
    localparam count_t BIT_MARK_MIN   = count_t'(BIT_MARK_UNITS * CLOCKS_PER_UNIT - HALF_UNIT);
    localparam count_t BIT_MARK_MAX   = count_t'(BIT_MARK_UNITS * CLOCKS_PER_UNIT + HALF_UNIT);
    localparam count_t ZERO_MIN       = count_t'(ZERO_SPACE_UNITS * CLOCKS_PER_UNIT - HALF_UNIT);
    localparam count_t ZERO_MAX       = count_t'(ZERO_SPACE_UNITS * CLOCKS_PER_UNIT + HALF_UNIT);
    localparam count_t ONE_MIN        = count_t'(ONE_SPACE_UNITS * CLOCKS_PER_UNIT - HALF_UNIT);
    localparam count_t ONE_MAX        = count_t'(ONE_SPACE_UNITS * CLOCKS_PER_UNIT + HALF_UNIT);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LEAD_MARK,
        ST_LEAD_SPACE,
        ST_BIT_MARK,
        ST_BIT_SPACE,
        ST_CHECK      // Frame accepted, waits out the stop mark
    } rx_state_t;

    rx_state_t   state;
    logic        sync_1;
    logic        sync_2;       // Synchronised line level
    logic        sync_3;       // Previous level, for edge detection
    count_t      count;        // Clocks spent at the current level
    logic [4:0]  bit_count;    // Bits already shifted in
    logic [31:0] shift_reg;    // Frame under assembly, LSB first
    logic        mark_start;
    logic        bit_is_zero;
    logic        bit_is_one;
    logic        frame_ok;
    ir_word_t    frame_next;   // Shift register with the current bit added

    assign mark_start  = !sync_2 && sync_3;  // Falling edge, start of a mark
    assign bit_is_zero = (count >= ZERO_MIN) && (count <= ZERO_MAX);
    assign bit_is_one  = (count >= ONE_MIN) && (count <= ONE_MAX);
    assign frame_next  = ir_word_t'({bit_is_one, shift_reg[31:1]});

    // Both inverted bytes must be exact complements
    assign frame_ok = (frame_next.inv_address == ~frame_next.address) &&
                      (frame_next.inv_command == ~frame_next.command);

    always_ff @(posedge clock_50) begin
        if (reset) begin
            sync_1     <= 1'b1;  // Line idles high
            sync_2     <= 1'b1;
            sync_3     <= 1'b1;
            state      <= ST_IDLE;
            count      <= '0;
            bit_count  <= '0;
            data_ready <= 1'b0;
            ir_data    <= '0;
        end else begin
            sync_1     <= ir_rxd;
            sync_2     <= sync_1;
            sync_3     <= sync_2;
            data_ready <= 1'b0;
            count      <= count + 1'b1;  // Overridden on every level change

            case (state)
                ST_IDLE: begin
                    count <= count_t'(1);  // First low cycle already counts
                    if (mark_start)
                        state <= ST_LEAD_MARK;
                end

                ST_LEAD_MARK: begin
                    if (sync_2) begin
                        count <= count_t'(1);
                        if (count >= LEAD_MARK_MIN && count <= LEAD_MARK_MAX)
                            state <= ST_LEAD_SPACE;
                        else
                            state <= ST_IDLE;
                    end else if (count > LEAD_MARK_MAX) begin
                        state <= ST_IDLE;  // Line stuck low
                    end
                end

                // A repeat code has a short leader space and fails this window
                ST_LEAD_SPACE: begin
                    if (!sync_2) begin
                        count     <= count_t'(1);
                        bit_count <= '0;
                        if (count >= LEAD_SPACE_MIN && count <= LEAD_SPACE_MAX)
                            state <= ST_BIT_MARK;
                        else
                            state <= ST_IDLE;
                    end else if (count > LEAD_SPACE_MAX) begin
                        state <= ST_IDLE;
                    end
                end

                ST_BIT_MARK: begin
                    if (sync_2) begin
                        count <= count_t'(1);
                        if (count >= BIT_MARK_MIN && count <= BIT_MARK_MAX)
                            state <= ST_BIT_SPACE;
                        else
                            state <= ST_IDLE;
                    end else if (count > BIT_MARK_MAX) begin
                        state <= ST_IDLE;
                    end
                end

                // Space length decides the bit, the next mark ends it
                ST_BIT_SPACE: begin
                    if (!sync_2) begin
                        count <= count_t'(1);
                        if (!(bit_is_zero || bit_is_one)) begin
                            state <= ST_IDLE;
                        end else if (bit_count == 5'd31) begin
                            if (frame_ok) begin  // Stop mark has begun
                                ir_data    <= frame_next;
                                data_ready <= 1'b1;
                                state      <= ST_CHECK;
                            end else begin
                                state <= ST_IDLE;
                            end
                        end else begin
                            shift_reg <= frame_next;
                            bit_count <= bit_count + 1'b1;
                            state     <= ST_BIT_MARK;
                        end
                    end else if (count > ONE_MAX) begin
                        state <= ST_IDLE;  // Stretched space
                    end
                end

                ST_CHECK: begin
                    if (sync_2)
                        state <= ST_IDLE;  // Stop mark over
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- ir_command_decoder.sv
`timescale 1ns/1ns

module ir_command_decoder import ir_pkg::*; #(
    parameter logic [7:0] DEVICE_ADDRESS = 8'h00  // Address this board answers to
) (
    input  logic     clock_50,
    input  logic     reset,
    input  logic     data_ready,     // Frame strobe from the receiver
    input  ir_word_t ir_data,
    output state_t   state_control,
    output logic     toggle,
    output logic     state_update    // One-cycle strobe on every state load
);

    logic   frame_for_us;
    logic   [7:0] command;

    // Only frames to our address are acted on
    assign frame_for_us = data_ready && (ir_data.address == DEVICE_ADDRESS);
    assign command      = ir_data.command;

    always_ff @(posedge clock_50) begin
        if (reset) begin
            state_control <= '0;
            toggle        <= 1'b0;
            state_update  <= 1'b0;
        end else begin
            state_update <= 1'b0;
            if (frame_for_us) begin
                case (command)
                    // State commands, low three bits are the state
                    CMD_STOP,
                    CMD_FORWARD,
                    CMD_BACK,
                    CMD_LEFT,
                    CMD_RIGHT,
                    CMD_SLOW,
                    CMD_FAST,
                    CMD_HOLD: begin
                        state_control <= state_t'(command[2:0]);
                        state_update  <= 1'b1;  // Also on a repeated press
                    end

                    CMD_TOGGLE: begin
                        toggle <= ~toggle;  // No UART report
                    end

                    default: begin
                        // Unknown command, nothing changes
                    end
                endcase
            end
        end
    end

endmodule

//--- uart_status_tx.sv
`timescale 1ns/1ns

module uart_status_tx import ir_pkg::*; #(
    parameter int unsigned BAUD_DIVISOR = 434  // Clocks per bit, 115200 at 50 MHz
) (
    input  logic   clock_50,
    input  logic   reset,
    input  logic   state_update,   // New state to report
    input  state_t state_control,
    output logic   uart_tx,        // 8N1 serial line, idles high
    output logic   busy            // Byte in flight
);

    localparam int unsigned BAUD_W = $clog2(BAUD_DIVISOR + 1);

    logic [BAUD_W-1:0] baud_count;
    logic [3:0]        bit_count;      // 0 start, 1..8 data, 9 stop
    logic [8:0]        shift_reg;      // Data bits then stop bit
    logic              pending_valid;  // One update waiting behind the current byte
    state_t            pending_state;
    logic              baud_tick;
    logic              byte_done;
    logic              can_start;

    assign baud_tick = (baud_count == BAUD_W'(BAUD_DIVISOR - 1));
    assign byte_done = busy && baud_tick && (bit_count == 4'd9);  // Stop bit ends
    assign can_start = !busy || byte_done;

    always_ff @(posedge clock_50) begin
        if (reset) begin
            uart_tx       <= 1'b1;
            busy          <= 1'b0;
            baud_count    <= '0;
            bit_count     <= '0;
            pending_valid <= 1'b0;
        end else if (can_start && (pending_valid || state_update)) begin
            // Start bit goes out next cycle
            uart_tx    <= 1'b0;
            busy       <= 1'b1;
            baud_count <= '0;
            bit_count  <= '0;
            if (pending_valid) begin
                shift_reg     <= {1'b1, state_to_ascii(pending_state)};
                pending_valid <= state_update;  // Update in the same cycle queues up
                pending_state <= state_control;
            end else begin
                shift_reg <= {1'b1, state_to_ascii(state_control)};
            end
        end else if (byte_done) begin
            busy       <= 1'b0;  // Line already high from the stop bit
            baud_count <= '0;
        end else if (busy) begin
            if (state_update) begin
                pending_valid <= 1'b1;  // Later update overwrites
                pending_state <= state_control;
            end
            if (baud_tick) begin
                baud_count <= '0;
                uart_tx    <= shift_reg[0];  // LSB first
                shift_reg  <= {1'b1, shift_reg[8:1]};
                bit_count  <= bit_count + 1'b1;
            end else begin
                baud_count <= baud_count + 1'b1;
            end
        end
    end

endmodule

//--- ir_top_level.sv
`timescale 1ns/1ns

module ir_top_level import ir_pkg::*; #(
    parameter int unsigned CLOCKS_PER_UNIT = 28125,  // 562.5 us at 50 MHz
    parameter logic [7:0]  DEVICE_ADDRESS  = 8'h00,
    parameter int unsigned BAUD_DIVISOR    = 434     // 115200 baud
) (
    input  logic     clock_50,       // Board clock
    input  logic     reset,
    input  logic     ir_rxd,         // Demodulated IR, low during a mark
    output logic     uart_tx,        // Status digits out
    output logic     uart_busy,
    output state_t   state_control,
    output logic     toggle,
    output ir_word_t ir_out          // Last valid frame
);

    logic data_ready;    // Receiver frame strobe
    logic state_update;  // Decoder state strobe

    // NEC frame decode and complement check
    ir_nec_receiver #(
        .CLOCKS_PER_UNIT(CLOCKS_PER_UNIT)
    ) ir_nec_receiver_inst (
        .clock_50  (clock_50),
        .reset     (reset),
        .ir_rxd    (ir_rxd),
        .data_ready(data_ready),
        .ir_data   (ir_out)
    );

    // Address filter and command mapping
    ir_command_decoder #(
        .DEVICE_ADDRESS(DEVICE_ADDRESS)
    ) ir_command_decoder_inst (
        .clock_50     (clock_50),
        .reset        (reset),
        .data_ready   (data_ready),
        .ir_data      (ir_out),
        .state_control(state_control),
        .toggle       (toggle),
        .state_update (state_update)
    );

    // One ASCII digit per state change
    uart_status_tx #(
        .BAUD_DIVISOR(BAUD_DIVISOR)
    ) uart_status_tx_inst (
        .clock_50     (clock_50),
        .reset        (reset),
        .state_update (state_update),
        .state_control(state_control),
        .uart_tx      (uart_tx),
        .busy         (uart_busy)
    );

endmodule

//--- ir_tb.sv
`timescale 1ns/1ns

module ir_tb import ir_pkg::*; ();

    localparam int unsigned CLOCKS_PER_UNIT  = 8;
    localparam logic [7:0]  DEVICE_ADDRESS   = 8'h00;
    localparam int unsigned BAUD_DIVISOR     = 16;
    localparam int          RESET_CYCLES     = 16;
    localparam int          NUM_ENTRIES      = 12;
    localparam int          TIMEOUT_CYCLES   = NUM_ENTRIES * 1800 + RESET_CYCLES;
    localparam int          UART_WAIT_CYCLES = 2 * 10 * BAUD_DIVISOR;  // Two byte times
    localparam int          STRETCH_BIT      = 10;  // Bit whose space gets stretched
    localparam int          STRETCH_UNITS    = 3;   // Pushes even a zero past the one window

    typedef enum logic [1:0] {
        FRAME_GOOD,
        FRAME_CORRUPT,
        FRAME_STRETCHED,
        FRAME_REPEAT
    } frame_kind_t;

    // Address, command, kind, expected ir_out, state, toggle, UART byte expected
    typedef struct packed {
        logic [7:0]  address;
        logic [7:0]  command;
        frame_kind_t kind;
        ir_word_t    exp_word;
        state_t      exp_state;
        logic        exp_toggle;
        logic        exp_uart;
    } stim_entry_t;

    logic        clock_50;
    logic        reset;
    logic        ir_rxd;
    logic        uart_tx;
    logic        uart_busy;
    state_t      state_control;
    logic        toggle;
    ir_word_t    ir_out;

    stim_entry_t stimulus [NUM_ENTRIES];
    logic [7:0]  rx_bytes [$];   // Filled by the UART monitor
    logic [7:0]  exp_bytes [$];  // Digits still owed by the DUT
    int          cycle_count = 0;

    ir_top_level #(
        .CLOCKS_PER_UNIT(CLOCKS_PER_UNIT),
        .DEVICE_ADDRESS (DEVICE_ADDRESS),
        .BAUD_DIVISOR   (BAUD_DIVISOR)
    ) ir_top_level_inst (
        .clock_50     (clock_50),
        .reset        (reset),
        .ir_rxd       (ir_rxd),
        .uart_tx      (uart_tx),
        .uart_busy    (uart_busy),
        .state_control(state_control),
        .toggle       (toggle),
        .ir_out       (ir_out)
    );

    initial clock_50 = 1'b0;
    always #50 clock_50 = ~clock_50;  // 100 ns period

    task automatic abort_test(string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_word(string name, ir_word_t actual, ir_word_t expected);
        logic [31:0] act_bits;
        logic [31:0] exp_bits;
        act_bits = actual;
        exp_bits = expected;
        if (act_bits !== exp_bits)
            abort_test($sformatf("mismatch at %0t ns: %s expected %h, got %h",
                                 $time, name, exp_bits, act_bits));
    endtask

    task automatic check_state(string name, state_t actual, state_t expected);
        if (actual !== expected)
            abort_test($sformatf("mismatch at %0t ns: %s expected %0d, got %0d",
                                 $time, name, expected, actual));
    endtask

    task automatic check_level(string name, logic actual, logic expected);
        if (actual !== expected)
            abort_test($sformatf("mismatch at %0t ns: %s expected %b, got %b",
                                 $time, name, expected, actual));
    endtask

    task automatic check_byte(string name, logic [7:0] actual, logic [7:0] expected);
        if (actual !== expected)
            abort_test($sformatf("mismatch at %0t ns: %s expected %h, got %h",
                                 $time, name, expected, actual));
    endtask

    // Hold the IR line for a whole number of units, entered on a falling edge
    task automatic drive_level(logic level, int units);
        ir_rxd = level;
        repeat (units * CLOCKS_PER_UNIT) @(negedge clock_50);
    endtask

    // Leaves the line low at the start of the stop mark
    task automatic send_frame(logic [7:0] address, logic [7:0] command, frame_kind_t kind);
        logic [31:0] bits;
        int          space_units;
        int          i;
        bits = {~command, command, ~address, address};  // Bit 0 goes out first
        if (kind == FRAME_CORRUPT)
            bits[24] = ~bits[24];  // Inverted command no longer matches
        drive_level(1'b0, LEADER_MARK_UNITS);
        if (kind == FRAME_REPEAT) begin
            drive_level(1'b1, REPEAT_SPACE_UNITS);
        end else begin
            drive_level(1'b1, LEADER_SPACE_UNITS);
            for (i = 0; i < 32; i++) begin
                space_units = bits[0] ? ONE_SPACE_UNITS : ZERO_SPACE_UNITS;
                if (kind == FRAME_STRETCHED && i == STRETCH_BIT)
                    space_units += STRETCH_UNITS;
                drive_level(1'b0, BIT_MARK_UNITS);
                drive_level(1'b1, space_units);
                bits = bits >> 1;
            end
        end
        ir_rxd = 1'b0;  // Stop mark
    endtask

    // Bounded wait until every owed digit has been received
    task automatic wait_for_uart();
        int waited;
        waited = 0;
        while (rx_bytes.size() < exp_bytes.size() && waited < UART_WAIT_CYCLES) begin
            @(negedge clock_50);
            waited++;
        end
        if (rx_bytes.size() < exp_bytes.size())
            abort_test("an expected UART byte never arrived");
    endtask

    // Received digits must match the owed ones in order, with nothing extra
    task automatic compare_uart_bytes();
        logic [7:0] got;
        while (rx_bytes.size() > 0) begin
            got = rx_bytes.pop_front();
            if (exp_bytes.size() == 0)
                abort_test($sformatf("UART sent byte %h although no state changed", got));
            else
                check_byte("uart_tx", got, exp_bytes.pop_front());
        end
    endtask

    task automatic load_table();
        // Address, command, kind, ir_out, state, toggle, UART byte
        stimulus[0]  = {8'h00, CMD_FORWARD, FRAME_GOOD,      32'hBE41_FF00, 3'd1, 1'b0, 1'b1};
        stimulus[1]  = {8'h00, CMD_LEFT,    FRAME_GOOD,      32'hBC43_FF00, 3'd3, 1'b0, 1'b1};
        stimulus[2]  = {8'h00, CMD_TOGGLE,  FRAME_GOOD,      32'hE01F_FF00, 3'd3, 1'b1, 1'b0};
        stimulus[3]  = {8'h00, CMD_STOP,    FRAME_CORRUPT,   32'hE01F_FF00, 3'd3, 1'b1, 1'b0};
        stimulus[4]  = {8'h00, CMD_STOP,    FRAME_STRETCHED, 32'hE01F_FF00, 3'd3, 1'b1, 1'b0};
        stimulus[5]  = {8'h00, CMD_STOP,    FRAME_REPEAT,    32'hE01F_FF00, 3'd3, 1'b1, 1'b0};
        stimulus[6]  = {8'h5A, CMD_HOLD,    FRAME_GOOD,      32'hB847_A55A, 3'd3, 1'b1, 1'b0};
        stimulus[7]  = {8'h00, 8'h12,       FRAME_GOOD,      32'hED12_FF00, 3'd3, 1'b1, 1'b0};
        stimulus[8]  = {8'h00, CMD_TOGGLE,  FRAME_GOOD,      32'hE01F_FF00, 3'd3, 1'b0, 1'b0};
        stimulus[9]  = {8'h00, CMD_FAST,    FRAME_GOOD,      32'hB946_FF00, 3'd6, 1'b0, 1'b1};
        stimulus[10] = {8'h00, CMD_FAST,    FRAME_GOOD,      32'hB946_FF00, 3'd6, 1'b0, 1'b1};
        stimulus[11] = {8'h00, CMD_STOP,    FRAME_GOOD,      32'hBF40_FF00, 3'd0, 1'b0, 1'b1};
    endtask

    // UART monitor, samples each bit in its middle on falling edges
    initial begin : uart_monitor
        logic [7:0] rx_byte;
        int         n;
        @(negedge reset);
        forever begin
            @(negedge clock_50);
            if (uart_tx === 1'b0) begin  // Start bit seen within its first cycle
                repeat (BAUD_DIVISOR / 2) @(negedge clock_50);
                if (uart_tx !== 1'b0)
                    abort_test("UART start bit did not last half a bit time");
                for (n = 0; n < 8; n++) begin
                    repeat (BAUD_DIVISOR) @(negedge clock_50);
                    rx_byte = {uart_tx, rx_byte[7:1]};  // LSB arrives first
                end
                repeat (BAUD_DIVISOR) @(negedge clock_50);
                if (uart_tx !== 1'b1)
                    abort_test("UART stop bit was low");
                rx_bytes.push_back(rx_byte);
            end
        end
    end

    always @(posedge clock_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
            abort_test($sformatf("timeout, the tests did not finish in %0d cycles",
                                 TIMEOUT_CYCLES));
    end

    initial begin : main_sequence
        stim_entry_t entry;
        ir_word_t    last_word;
        state_t      last_state;
        logic        last_toggle;
        int          gap_units;
        int          idx;

        reset  = 1'b1;
        ir_rxd = 1'b1;  // IR line idles high
        void'($urandom(66));
        load_table();
        last_word   = '0;
        last_state  = '0;
        last_toggle = 1'b0;

        repeat (RESET_CYCLES) @(negedge clock_50);
        reset = 1'b0;
        @(negedge clock_50);
        check_level("uart_tx", uart_tx, 1'b1);
        check_level("uart_busy", uart_busy, 1'b0);
        check_state("state_control", state_control, 3'd0);
        check_level("toggle", toggle, 1'b0);
        check_word("ir_out", ir_out, 32'h0000_0000);

        for (idx = 0; idx < NUM_ENTRIES; idx++) begin
            entry     = stimulus[idx];
            gap_units = 20 + ($urandom % 41);  // 20 to 60 units of idle
            drive_level(1'b1, gap_units);
            send_frame(entry.address, entry.command, entry.kind);

            // Frame lands three cycles into the stop mark, decoder one later
            repeat (2) @(negedge clock_50);
            check_word("ir_out", ir_out, last_word);
            @(negedge clock_50);
            check_word("ir_out", ir_out, entry.exp_word);
            check_state("state_control", state_control, last_state);
            check_level("toggle", toggle, last_toggle);
            @(negedge clock_50);
            check_state("state_control", state_control, entry.exp_state);
            check_level("toggle", toggle, entry.exp_toggle);
            repeat (BIT_MARK_UNITS * CLOCKS_PER_UNIT - 4) @(negedge clock_50);
            ir_rxd = 1'b1;  // Stop mark over

            if (entry.exp_uart) begin
                exp_bytes.push_back(8'h30 + {5'b00000, entry.exp_state});  // ASCII digit
                wait_for_uart();
            end
            compare_uart_bytes();
            last_word   = entry.exp_word;
            last_state  = entry.exp_state;
            last_toggle = entry.exp_toggle;
        end

        // Quiet line, catch any late or extra digit
        repeat (UART_WAIT_CYCLES) @(negedge clock_50);
        compare_uart_bytes();
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- flist.f
ir_pkg.sv
ir_nec_receiver.sv
ir_command_decoder.sv
uart_status_tx.sv
ir_top_level.sv
ir_tb.sv

//--- Makefile
SOURCES = ir_pkg.sv ir_nec_receiver.sv ir_command_decoder.sv uart_status_tx.sv \
          ir_top_level.sv ir_tb.sv

.PHONY: all run lint clean

all: run

obj_dir/Vir_tb: flist.f $(SOURCES)
	verilator --binary --timing --top-module ir_tb -f flist.f

run: obj_dir/Vir_tb
	./obj_dir/Vir_tb

lint:
	verilator --lint-only --timing -Wall --top-module ir_tb -f flist.f

clean:
	rm -rf obj_dir
